/* Makefile */
TOP := l1d_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+rtl
rtl/l1d_pkg.sv
rtl/l1d_controller.sv
rtl/l1d_data_array.sv
rtl/l2_mem.sv
rtl/l1d_top.sv
dv/l1d_tb.sv

/* dv/l1d_tb.sv */
`timescale 1ns/1ps
`include "l1d_params.svh"

module l1d_tb;

    localparam int N_RAND = 40;
    localparam int LINES  = `L1D_SETS * `L1D_WAYS;
    localparam int WORDS  = 1 << (`L1D_TAG_W + `L1D_INDEX_W);

    typedef enum logic [1:0] {op_read, op_write, op_flush} op_t;

    typedef struct packed {
        op_t             op;
        l1d_pkg::tag_t   tag;
        l1d_pkg::index_t index;
        l1d_pkg::data_t  wdata;
    } entry_t;

    logic              clk;
    logic              nrst;
    logic              flush;
    l1d_pkg::cpu_req_t req;
    logic              stall;
    logic              miss;
    l1d_pkg::data_t    read_data;

    entry_t table_q[$];
    int     seed = 32'ha7c5_ca43;
    int     cycles = 0;
    int     limit = 0;
    int     total_miss = 0;
    int     exp_total = 0;

    // reference model state
    l1d_pkg::data_t       l2_ref [WORDS];
    l1d_pkg::data_t       data_ref [LINES];
    l1d_pkg::tag_t        tag_ref [LINES];
    logic [LINES-1:0]     valid_ref;
    logic [LINES-1:0]     dirty_ref;
    logic [`L1D_SETS-1:0] lru_ref;

    l1d_top UUT (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .flush     (flush),
        .stall     (stall),
        .miss      (miss),
        .read_data (read_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // every miss pulse of the run, also outside request windows
    always @(negedge clk)
    begin
        if (nrst && miss)
            total_miss = total_miss + 1;
    end

    task automatic check_data(input string name, input l1d_pkg::data_t got,
                              input l1d_pkg::data_t exp);
        if (got !== exp)
        begin
            $display("error: %0t %s expected %h got %h", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error: %0t %s expected %b got %b", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("error: %0t %s expected %0d got %0d", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "count mismatch");
        end
    endtask

    function automatic void push_entry(input op_t op, input l1d_pkg::tag_t tag,
                                       input l1d_pkg::index_t index,
                                       input l1d_pkg::data_t wdata);
        entry_t e;
        e.op    = op;
        e.tag   = tag;
        e.index = index;
        e.wdata = wdata;
        table_q.push_back(e);
    endfunction

    // predicts one access and updates the model
    function automatic void model_access(input entry_t e, output l1d_pkg::data_t rd,
                                         output logic m);
        l1d_pkg::line_t way0;
        l1d_pkg::line_t way1;
        l1d_pkg::line_t w;
        logic           hit0;
        logic           hit1;
        way0 = {e.index, 1'b0};
        way1 = {e.index, 1'b1};
        hit0 = valid_ref[way0] && (tag_ref[way0] == e.tag);
        hit1 = valid_ref[way1] && (tag_ref[way1] == e.tag);
        if (!valid_ref[way0] || hit0)
            w = way0;
        else if (!valid_ref[way1] || hit1)
            w = way1;
        else
            w = {e.index, lru_ref[e.index]};
        m = !(hit0 || hit1);
        if (m)
        begin
            if (valid_ref[w] && dirty_ref[w])
                l2_ref[{tag_ref[w], e.index}] = data_ref[w];   // victim back to l2
            data_ref[w]  = l2_ref[{e.tag, e.index}];
            tag_ref[w]   = e.tag;
            valid_ref[w] = 1'b1;
            dirty_ref[w] = 1'b0;
        end
        lru_ref[e.index] = !w[0];
        if (e.op == op_write)
        begin
            data_ref[w]  = e.wdata;
            dirty_ref[w] = 1'b1;
        end
        rd = data_ref[w];
    endfunction

    task automatic build_table();
        logic [31:0]   r;
        l1d_pkg::tag_t t;
        // cold miss then hit
        push_entry(op_read, 8'h11, 2'd0, '0);
        push_entry(op_read, 8'h11, 2'd0, '0);
        push_entry(op_write, 8'h22, 2'd1, 32'hdead_beef);
        push_entry(op_read, 8'h22, 2'd1, '0);
        // three dirty tags in set 3
        push_entry(op_write, 8'h31, 2'd3, 32'h1111_aaaa);
        push_entry(op_write, 8'h42, 2'd3, 32'h2222_bbbb);
        push_entry(op_write, 8'h53, 2'd3, 32'h3333_cccc);
        push_entry(op_read, 8'h31, 2'd3, '0);
        push_entry(op_read, 8'h42, 2'd3, '0);
        push_entry(op_read, 8'h53, 2'd3, '0);
        // flush of a clean line then of a dirty one
        push_entry(op_read, 8'h64, 2'd2, '0);
        push_entry(op_read, 8'h64, 2'd2, '0);
        push_entry(op_flush, '0, '0, '0);
        push_entry(op_read, 8'h64, 2'd2, '0);
        push_entry(op_write, 8'h75, 2'd2, 32'h5555_dddd);
        push_entry(op_flush, '0, '0, '0);
        push_entry(op_read, 8'h75, 2'd2, '0);
        for (int i = 0; i < N_RAND; i++)
        begin
            r = $random(seed);
            case (r[5:4] % 3)
                0:       t = 8'h0c;
                1:       t = 8'h8e;
                default: t = 8'hf3;
            endcase
            if (r[3:0] == 4'd0)
                push_entry(op_flush, '0, '0, '0);
            else
                push_entry(r[0] ? op_write : op_read, t, r[6] ? 2'd1 : 2'd2, $random(seed));
        end
    endtask

    task automatic run_entry(input entry_t e);
        l1d_pkg::data_t exp_data;
        logic           exp_miss;
        int             pulses;
        int             busy;
        pulses = 0;
        busy   = 0;
        if (e.op == op_flush)
        begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            valid_ref = '0;     // dirty data is dropped
            check_bit("stall", stall, 1'b0);
        end
        else
        begin
            model_access(e, exp_data, exp_miss);
            req.tag   = e.tag;
            req.index = e.index;
            req.read  = (e.op == op_read);
            req.write = (e.op == op_write);
            req.wdata = e.wdata;
            @(posedge clk);
            do
            begin
                @(negedge clk);
                if (miss)
                    pulses++;
                if (stall)
                    busy++;
            end while (stall);
            check_count("miss pulses", pulses, exp_miss ? 1 : 0);
            if (!exp_miss)
                check_count("stall cycles on hit", busy, 2);
            if (e.op == op_read)
                check_data("read_data", read_data, exp_data);
            exp_total += exp_miss ? 1 : 0;
            req.read  = 1'b0;
            req.write = 1'b0;
        end
    endtask

    initial
    begin
        nrst  = 1'b0;
        flush = 1'b0;
        req   = '0;
        for (int i = 0; i < WORDS; i++)
            l2_ref[i] = l1d_pkg::data_t'(i) * 32'h0101_0101;
        valid_ref = '0;
        dirty_ref = '0;
        lru_ref   = '0;
        build_table();
        limit = 64 * table_q.size() + 16 + 2;
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_bit("stall", stall, 1'b0);
        check_bit("miss", miss, 1'b0);
        foreach (table_q[i])
            run_entry(table_q[i]);
        check_count("total miss pulses", total_miss, exp_total);
        $display("Test passed");
        $finish;
    end

endmodule

/* rtl/l1d_controller.sv */
`timescale 1ns/1ps
`include "l1d_params.svh"

module l1d_controller (
    input  logic                clk,
    input  logic                nrst,
    input  l1d_pkg::cpu_req_t   req,
    input  logic                flush,
    input  logic                l2_ready,
    output logic                stall,
    output logic                refill,
    output logic                update,
    output logic                read_l2,
    output logic                write_l2,
    output logic                miss,
    output l1d_pkg::l2_index_t  l2_index,
    output l1d_pkg::l2_tag_t    l2_tag,
    output l1d_pkg::line_t      line
);

    localparam int LINES = `L1D_SETS * `L1D_WAYS;
    localparam int LOW_W = `L1D_TAG_W - `L2_TAG_W;   // tag bits that go into the l2 index

    l1d_pkg::ctrl_state_t state;
    l1d_pkg::ctrl_state_t next_state;

    l1d_pkg::tag_t        tag_arr [LINES];
    l1d_pkg::tag_t        victim_tag;
    l1d_pkg::line_t       line0;
    l1d_pkg::line_t       line1;
    logic [LINES-1:0]     valid;
    logic [LINES-1:0]     dirty;
    logic [`L1D_SETS-1:0] lru;    // way to replace next

    logic way_q;
    logic check;      // holds the chosen way across a refill
    logic hit;
    logic first;      // first compare cycle of a request
    logic match0;
    logic match1;
    logic fill_done;

    assign line0 = {req.index, 1'b0};
    assign line1 = {req.index, 1'b1};
    assign line  = {req.index, way_q};

    assign match0 = valid[line0] && (req.tag == tag_arr[line0]);
    assign match1 = valid[line1] && (req.tag == tag_arr[line1]);

    assign first     = (state == l1d_pkg::s_compare) && !hit && !miss;
    assign fill_done = (state == l1d_pkg::s_allocate) && l2_ready;

    assign stall    = (state != l1d_pkg::s_idle);
    assign read_l2  = (state == l1d_pkg::s_allocate);
    assign write_l2 = (state == l1d_pkg::s_write_back);

    // write-back uses the victim's address and allocate the request's
    assign victim_tag = tag_arr[line];
    assign l2_tag   = write_l2 ? victim_tag[`L1D_TAG_W-1 -: `L2_TAG_W]
                               : req.tag[`L1D_TAG_W-1 -: `L2_TAG_W];
    assign l2_index = write_l2 ? {victim_tag[LOW_W-1:0], req.index}
                               : {req.tag[LOW_W-1:0], req.index};

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= l1d_pkg::s_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            l1d_pkg::s_idle:
                if (req.read || req.write)
                    next_state = l1d_pkg::s_compare;
            l1d_pkg::s_compare:
                if (hit)
                    next_state = l1d_pkg::s_idle;
                else if (miss)
                    // dirty victim goes back first on reads too
                    next_state = (valid[line] && dirty[line]) ? l1d_pkg::s_write_back
                                                              : l1d_pkg::s_allocate;
            l1d_pkg::s_write_back:
                if (l2_ready)
                    next_state = l1d_pkg::s_allocate;
            l1d_pkg::s_allocate:
                if (l2_ready)
                    next_state = l1d_pkg::s_compare;
            default:
                next_state = l1d_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            check <= 1'b0;
        else if (state == l1d_pkg::s_allocate)
            check <= 1'b1;
        else if (state == l1d_pkg::s_idle)
            check <= 1'b0;
    end

    // way choice on entry to compare
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            way_q <= 1'b0;
        else if (first && !check)
        begin
            if (!valid[line0] || match0)
                way_q <= 1'b0;
            else if (!valid[line1] || match1)
                way_q <= 1'b1;
            else
                way_q <= lru[req.index];
        end
    end

    // hit and miss are one-cycle results of the first compare cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end
        else if (first)
        begin
            hit  <= match0 || match1;
            miss <= !(match0 || match1);
        end
        else
        begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            refill <= 1'b0;
            update <= 1'b0;
        end
        else
        begin
            refill <= fill_done;
            update <= first && (match0 || match1) && req.write;   // lands with hit
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru <= '0;
        else if ((state == l1d_pkg::s_compare) && hit)
            lru[req.index] <= !way_q;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            dirty <= '0;
        else if (fill_done)
            dirty[line] <= 1'b0;
        else if (update)
            dirty[line] <= 1'b1;
    end

    // flush drops valid only
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid <= '0;
        else if ((state == l1d_pkg::s_idle) && flush)
            valid <= '0;
        else if (fill_done)
            valid[line] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill_done)
            tag_arr[line] <= req.tag;
    end

    a_req_onehot: assert property (@(posedge clk) disable iff (!nrst)
        !(req.read && req.write));

endmodule

/* rtl/l1d_data_array.sv */
`timescale 1ns/1ps
`include "l1d_params.svh"

module l1d_data_array (
    input  logic            clk,
    input  logic            nrst,
    input  l1d_pkg::line_t  line,
    input  logic            refill,
    input  logic            update,
    input  l1d_pkg::data_t  refill_data,
    input  l1d_pkg::data_t  cpu_wdata,
    output l1d_pkg::data_t  rdata
);

    localparam int LINES = `L1D_SETS * `L1D_WAYS;

    l1d_pkg::data_t words [LINES];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < LINES; i++)
                words[i] <= '0;
        end
        else if (refill)
            words[line] <= refill_data;     // line fill from l2
        else if (update)
            words[line] <= cpu_wdata;       // write hit
    end

    // cpu read data and write-back data share this port
    assign rdata = words[line];

    a_line_known: assert property (@(posedge clk) disable iff (!nrst)
        (refill || update) |-> !$isunknown(line));

    // refill has priority above, so an update in the same cycle would be lost
    a_refill_update: assert property (@(posedge clk) disable iff (!nrst)
        !(refill && update));

endmodule

/* rtl/l1d_params.svh */
`ifndef L1D_PARAMS_SVH
`define L1D_PARAMS_SVH

// cpu side address split
`define L1D_TAG_W       8
`define L1D_INDEX_W     2

// cache geometry, one word per line
`define L1D_SETS        4
`define L1D_WAYS        2
`define L1D_DATA_W      32

// l2 address split, index is {tag[2:0], set index}
`define L2_INDEX_W      5
`define L2_TAG_W        5

// cycles from strobe to ready
`define L2_LATENCY      4

`endif

/* rtl/l1d_pkg.sv */
`include "l1d_params.svh"

package l1d_pkg;

    typedef logic [`L1D_TAG_W-1:0]   tag_t;
    typedef logic [`L1D_INDEX_W-1:0] index_t;
    typedef logic [`L1D_DATA_W-1:0]  data_t;

    typedef logic [`L2_INDEX_W-1:0]  l2_index_t;
    typedef logic [`L2_TAG_W-1:0]    l2_tag_t;

    // {set index, way}
    typedef logic [`L1D_INDEX_W:0]   line_t;

    typedef enum logic [1:0] {
        s_idle,
        s_compare,
        s_write_back,
        s_allocate
    } ctrl_state_t;

    typedef struct packed {
        tag_t   tag;
        index_t index;
        logic   read;
        logic   write;
        data_t  wdata;
    } cpu_req_t;

endpackage

/* rtl/l1d_top.sv */
`timescale 1ns/1ps

module l1d_top (
    input  logic               clk,
    input  logic               nrst,
    input  l1d_pkg::cpu_req_t  req,
    input  logic               flush,
    output logic               stall,
    output logic               miss,
    output l1d_pkg::data_t     read_data
);

    logic               refill;
    logic               update;
    logic               read_l2;
    logic               write_l2;
    logic               l2_ready;
    l1d_pkg::l2_index_t l2_index;
    l1d_pkg::l2_tag_t   l2_tag;
    l1d_pkg::line_t     line;
    l1d_pkg::data_t     l2_rdata;

    l1d_controller u_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .req      (req),
        .flush    (flush),
        .l2_ready (l2_ready),
        .stall    (stall),
        .refill   (refill),
        .update   (update),
        .read_l2  (read_l2),
        .write_l2 (write_l2),
        .miss     (miss),
        .l2_index (l2_index),
        .l2_tag   (l2_tag),
        .line     (line)
    );

    l1d_data_array u_data (
        .clk         (clk),
        .nrst        (nrst),
        .line        (line),
        .refill      (refill),
        .update      (update),
        .refill_data (l2_rdata),
        .cpu_wdata   (req.wdata),
        .rdata       (read_data)
    );

    // victim word for write-back comes off the same read port
    l2_mem u_l2 (
        .clk   (clk),
        .nrst  (nrst),
        .read  (read_l2),
        .write (write_l2),
        .index (l2_index),
        .tag   (l2_tag),
        .wdata (read_data),
        .rdata (l2_rdata),
        .ready (l2_ready)
    );

endmodule

/* rtl/l2_mem.sv */
`timescale 1ns/1ps
`include "l1d_params.svh"

module l2_mem (
    input  logic                clk,
    input  logic                nrst,
    input  logic                read,
    input  logic                write,
    input  l1d_pkg::l2_index_t  index,
    input  l1d_pkg::l2_tag_t    tag,
    input  l1d_pkg::data_t      wdata,
    output l1d_pkg::data_t      rdata,
    output logic                ready
);

    localparam int ADDR_W = `L2_TAG_W + `L2_INDEX_W;
    localparam int WORDS  = 1 << ADDR_W;
    localparam int CNT_W  = $clog2(`L2_LATENCY) + 1;

    l1d_pkg::data_t    mem [WORDS];
    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0]  cnt;
    logic              rd_done;   // set once served until read drops
    logic              wr_done;
    logic              pending;
    logic              last;

    assign addr    = {tag, index};
    assign pending = (read && !rd_done) || (write && !wr_done);
    assign last    = pending && (cnt == CNT_W'(`L2_LATENCY - 1));

    // word = address * 0x01010101
    initial
    begin
        for (int i = 0; i < WORDS; i++)
            mem[i] = l1d_pkg::data_t'(i) * 32'h0101_0101;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            cnt     <= '0;
            ready   <= 1'b0;
            rd_done <= 1'b0;
            wr_done <= 1'b0;
        end
        else
        begin
            ready <= last;
            if (last || !pending)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
            if (!read)
                rd_done <= 1'b0;
            else if (last)
                rd_done <= 1'b1;
            if (!write)
                wr_done <= 1'b0;
            else if (last)
                wr_done <= 1'b1;
        end
    end

    always @(posedge clk)
    begin
        if (ready && write)
            mem[addr] <= wdata;
    end

    always_ff @(posedge clk)
    begin
        if (last && read)
            rdata <= mem[addr];     // held until the next read
    end

    // one access at a time on the shared address
    a_read_write: assert property (@(posedge clk) disable iff (!nrst)
        !(read && write));

endmodule
